// ==== common/mainBusPkg.sv ====
// Address map, interrupt channel table and input bit positions of the main board.
// Blocks import what they need from here.
package mainBusPkg;

	// Banked ROM window at F800-FFFF
	localparam logic [4:0] BANK_WIN_BASE = 5'b11111;

	// Input and DIP switch read ports
	localparam logic [15:0] ADDR_SYS  = 16'hF603;
	localparam logic [15:0] ADDR_P1   = 16'hF602;
	localparam logic [15:0] ADDR_P2   = 16'hF601;
	localparam logic [15:0] ADDR_DSW2 = 16'hF600;
	localparam logic [7:0]  PAGE_DSW0 = 8'hF2;
	localparam logic [7:0]  PAGE_DSW1 = 8'hF4;

	// Control register write addresses
	localparam logic [15:0] ADDR_IRQCTL  = 16'hE044;
	localparam logic [15:0] ADDR_BANKCTL = 16'hF000;

	// Channel 0 follows tick bit 0 as NMI, the other two share IRQ
	localparam int NUM_IRQ_CH = 3;
	localparam logic [3:0] CH_TICK_BIT [NUM_IRQ_CH] = '{4'd0, 4'd3, 4'd4};
	localparam logic       CH_IS_NMI   [NUM_IRQ_CH] = '{1'b1, 1'b0, 1'b0};

	// System byte layout
	localparam logic [2:0] SYS_COIN    = 3'd0;
	localparam logic [2:0] SYS_P1START = 3'd3;
	localparam logic [2:0] SYS_P2START = 3'd4;

	// Player byte layout, same for both players
	localparam logic [2:0] PL_LEFT  = 3'd0;
	localparam logic [2:0] PL_RIGHT = 3'd1;
	localparam logic [2:0] PL_UP    = 3'd2;
	localparam logic [2:0] PL_DOWN  = 3'd3;
	localparam logic [2:0] PL_BTN_A = 3'd4;
	localparam logic [2:0] PL_BTN_B = 3'd5;
endpackage

// ==== common/cpuBusIf.sv ====
// CPU bus bundle from the top level to the address decoder and control registers.
interface cpuBusIf;

	logic [15:0] addr;
	logic [7:0]  wdata;
	// Memory cycle, with wr marking a write
	logic        mreq;
	logic        wr;
	// Board-wide enable, qualifies every state update
	logic        clkEn;

	modport source (
		output addr,
		output wdata,
		output mreq,
		output wr,
		output clkEn
	);

	modport sink (
		input addr,
		input wdata,
		input mreq,
		input wr,
		input clkEn
	);
endinterface

// ==== design/busDecoder.sv ====
// Address decode of the CPU bus: ROM address and valid, input bytes and read data.
// Purely combinational, reads settle in the same cycle.
module busDecoder (
	cpuBusIf.sink       bus,
	input  logic [2:0]  bankSel,
	input  logic [2:0]  sysIn,
	input  logic [5:0]  p1In,
	input  logic [5:0]  p2In,
	input  logic [7:0]  dsw0,
	input  logic [7:0]  dsw1,
	input  logic [7:0]  dsw2,
	input  logic        vidValid,
	input  logic [7:0]  vidRdata,
	input  logic [7:0]  romData,
	output logic [15:0] romAddr,
	output logic        romValid,
	output logic [7:0]  cpuRdata
);
	import mainBusPkg::*;

	logic       inWindow;
	logic       csSys;
	logic       csP1;
	logic       csP2;
	logic       csDsw0;
	logic       csDsw1;
	logic       csDsw2;
	logic [7:0] sysBits;

	// Active high controls into their byte slots, inverted for the bus
	function automatic logic [7:0] packPlayer(input logic [5:0] raw);
		logic [7:0] bits;
		bits = '0;
		bits[PL_LEFT]  = raw[0];
		bits[PL_RIGHT] = raw[1];
		bits[PL_UP]    = raw[2];
		bits[PL_DOWN]  = raw[3];
		bits[PL_BTN_A] = raw[4];
		bits[PL_BTN_B] = raw[5];
		return ~bits;
	endfunction

	assign inWindow = (bus.addr[15:11] == BANK_WIN_BASE);

	// 2 KB banked window, fixed upper ROM, then the lower 32 KB
	always_comb begin
		if (inWindow) begin
			romAddr = {2'b11, bankSel, bus.addr[10:0]};
		end else if (bus.addr[15]) begin
			romAddr = {2'b10, bus.addr[13:0]};
		end else begin
			romAddr = {1'b0, bus.addr[14:0]};
		end
	end

	// C000-F7FF is I/O space, not ROM
	assign romValid = bus.mreq & (inWindow | (bus.addr[15:14] != 2'b11));

	assign csSys  = bus.mreq & (bus.addr == ADDR_SYS);
	assign csP1   = bus.mreq & (bus.addr == ADDR_P1);
	assign csP2   = bus.mreq & (bus.addr == ADDR_P2);
	assign csDsw2 = bus.mreq & (bus.addr == ADDR_DSW2);
	assign csDsw0 = bus.mreq & (bus.addr[15:8] == PAGE_DSW0);
	assign csDsw1 = bus.mreq & (bus.addr[15:8] == PAGE_DSW1);

	always_comb begin
		sysBits = '0;
		sysBits[SYS_COIN]    = sysIn[0];
		sysBits[SYS_P1START] = sysIn[1];
		sysBits[SYS_P2START] = sysIn[2];
	end

	// First match wins, video has top priority
	always_comb begin
		if (vidValid)    cpuRdata = vidRdata;
		else if (romValid) cpuRdata = romData;
		else if (csSys)  cpuRdata = ~sysBits;
		else if (csP1)   cpuRdata = packPlayer(p1In);
		else if (csP2)   cpuRdata = packPlayer(p2In);
		else if (csDsw0) cpuRdata = dsw0;
		else if (csDsw1) cpuRdata = dsw1;
		else if (csDsw2) cpuRdata = dsw2;
		else             cpuRdata = 8'h00;
	end
endmodule

// ==== design/ctrlRegs.sv ====
// Bank select and interrupt mask registers, written by the CPU.
// maskClear flags the mask bits that a mask write sets to 0.
module ctrlRegs (
	input  logic                                 MCLK,
	input  logic                                 RESET,
	cpuBusIf.sink                                bus,
	output logic [2:0]                           bankSel,
	output logic [mainBusPkg::NUM_IRQ_CH-1:0]    irqMask,
	output logic [mainBusPkg::NUM_IRQ_CH-1:0]    maskClear
);
	import mainBusPkg::*;

	logic wrCycle;
	logic bankWrite;
	logic irqWrite;

	assign wrCycle   = bus.clkEn & bus.mreq & bus.wr;
	assign bankWrite = wrCycle & (bus.addr == ADDR_BANKCTL);
	assign irqWrite  = wrCycle & (bus.addr == ADDR_IRQCTL);

	// Valid during the write cycle, so channels drop on the same edge
	assign maskClear = irqWrite ? ~bus.wdata[NUM_IRQ_CH-1:0] : '0;

	always_ff @(posedge MCLK) begin
		if (RESET) begin
			bankSel <= '0;
			irqMask <= '0;
		end else begin
			// Bank number sits in the top three data bits
			if (bankWrite) begin
				bankSel <= bus.wdata[7:5];
			end
			if (irqWrite) begin
				irqMask <= bus.wdata[NUM_IRQ_CH-1:0];
			end
		end
	end
endmodule

// ==== irqGen/vlineTicker.sv ====
// Counts 16-line boundaries of the vertical counter for the interrupt channels.
// tickStep pulses once per boundary, fireVec holds the tick bit that rose.
module vlineTicker (
	input  logic       MCLK,
	input  logic       RESET,
	input  logic       clkEn,
	input  logic [8:0] vPos,
	output logic       tickStep,
	output logic [8:0] fireVec
);
	logic [8:0] prevV;
	logic [8:0] tick;
	logic [8:0] tickInc;
	logic       waitSync;
	logic       boundary;

	assign tickInc = tick + 9'd1;

	// New line that is a multiple of 16, seen once per visit
	assign boundary = (vPos != prevV) && (vPos[3:0] == 4'd0);

	always_ff @(posedge MCLK) begin
		if (RESET) begin
			// Start off line 0 so the first line 0 counts
			prevV    <= 9'd1;
			tick     <= '0;
			waitSync <= 1'b1;
			tickStep <= 1'b0;
			fireVec  <= '0;
		end else if (clkEn) begin
			tickStep <= boundary;
			if (boundary) begin
				prevV <= vPos;
				// First frame start after reset aligns the count
				if (waitSync && (vPos == 9'd0)) begin
					tick     <= '0;
					waitSync <= 1'b0;
					fireVec  <= '0;
				end else begin
					tick    <= tickInc;
					// Lowest zero bit of the old count, the one that carries in
					fireVec <= ~tick & tickInc;
				end
			end
		end
	end
endmodule

// ==== irqGen/irqChannel.sv ====
// One interrupt source: latches its tick bit under the mask at each boundary.
// Instantiated once per entry of the channel table.
module irqChannel (
	input  logic MCLK,
	input  logic RESET,
	input  logic clkEn,
	input  logic tickStep,
	input  logic fire,
	input  logic maskBit,
	input  logic maskClear,
	output logic active
);
	logic loadVal;

	// Masked channels never latch a request
	assign loadVal = fire & maskBit;

	always_ff @(posedge MCLK) begin
		if (RESET) begin
			active <= 1'b0;
		end else if (clkEn) begin
			// Mask removal acknowledges, even against a boundary
			if (maskClear) begin
				active <= 1'b0;
			end else if (tickStep) begin
				// Level holds until the next boundary
				active <= loadVal;
			end
		end
	end
endmodule

// ==== irqGen/irqMerge.sv ====
// Combines the channel requests onto the CPU NMI and IRQ lines.
// Both lines are registered outputs.
module irqMerge #(
	parameter int NUM_CH = mainBusPkg::NUM_IRQ_CH
) (
	input  logic              MCLK,
	input  logic              RESET,
	input  logic              clkEn,
	input  logic [NUM_CH-1:0] chanActive,
	output logic              nmi,
	output logic              irq
);
	import mainBusPkg::*;

	logic nmiAny;
	logic irqAny;

	// Channel table picks the line for each channel
	always_comb begin
		nmiAny = 1'b0;
		irqAny = 1'b0;
		for (int k = 0; k < NUM_CH; k++) begin
			if (CH_IS_NMI[k]) nmiAny |= chanActive[k];
			else irqAny |= chanActive[k];
		end
	end

	always_ff @(posedge MCLK) begin
		if (RESET) begin
			nmi <= 1'b0;
			irq <= 1'b0;
		end else if (clkEn) begin
			nmi <= nmiAny;
			irq <= irqAny;
		end
	end
endmodule

// ==== design/mainBoard.sv ====
// Main CPU glue of the arcade board: bus decode, control registers and interrupts.
// The CPU, ROM and video memories connect to the plain ports.
module mainBoard (
	input  logic        MCLK,
	input  logic        RESET,
	input  logic        clkEn,
	input  logic [8:0]  vPos,
	input  logic [15:0] cpuAddr,
	input  logic [7:0]  cpuWdata,
	input  logic        cpuMreq,
	input  logic        cpuWr,
	output logic [7:0]  cpuRdata,
	input  logic [2:0]  sysIn,
	input  logic [5:0]  p1In,
	input  logic [5:0]  p2In,
	input  logic [7:0]  dsw0,
	input  logic [7:0]  dsw1,
	input  logic [7:0]  dsw2,
	input  logic        vidValid,
	input  logic [7:0]  vidRdata,
	output logic [15:0] romAddr,
	output logic        romValid,
	input  logic [7:0]  romData,
	output logic        nmi,
	output logic        irq
);
	import mainBusPkg::*;

	logic [2:0]            bankSel;
	logic [NUM_IRQ_CH-1:0] irqMask;
	logic [NUM_IRQ_CH-1:0] maskClear;
	logic [NUM_IRQ_CH-1:0] chanOut;
	logic                  tickStep;
	logic [8:0]            fireVec;

	cpuBusIf bus ();

	assign bus.addr  = cpuAddr;
	assign bus.wdata = cpuWdata;
	assign bus.mreq  = cpuMreq;
	assign bus.wr    = cpuWr;
	assign bus.clkEn = clkEn;

	busDecoder u_decoder (
		.bus(bus.sink), .bankSel, .sysIn, .p1In, .p2In, .dsw0, .dsw1, .dsw2,
		.vidValid, .vidRdata, .romData, .romAddr, .romValid, .cpuRdata
	);

	ctrlRegs u_ctrl (.MCLK, .RESET, .bus(bus.sink), .bankSel, .irqMask, .maskClear);

	vlineTicker u_ticker (.MCLK, .RESET, .clkEn, .vPos, .tickStep, .fireVec);

	// Each channel watches the tick bit given by the channel table
	for (genvar k = 0; k < NUM_IRQ_CH; k++) begin : gChan
		irqChannel u_chan (
			.MCLK, .RESET, .clkEn, .tickStep,
			.fire(fireVec[CH_TICK_BIT[k]]),
			.maskBit(irqMask[k]),
			.maskClear(maskClear[k]),
			.active(chanOut[k])
		);
	end

	irqMerge #(.NUM_CH(NUM_IRQ_CH)) u_merge (
		.MCLK, .RESET, .clkEn, .chanActive(chanOut), .nmi, .irq
	);
endmodule

// ==== dv/mainBoard_assertions.sv ====
// Concurrent checks on the main board outputs and interrupt timing.
// Bound into every mainBoard instance.
module mainBoardChecks (
	input logic                              MCLK,
	input logic                              RESET,
	input logic                              cpuMreq,
	input logic                              romValid,
	input logic                              vidValid,
	input logic [7:0]                        cpuRdata,
	input logic [7:0]                        romData,
	input logic                              nmi,
	input logic                              irq,
	input logic                              tickStep,
	input logic [mainBusPkg::NUM_IRQ_CH-1:0] maskClear
);
	// Both interrupt lines held low through reset
	resetQuiet: assert property (@(posedge MCLK) RESET && $past(RESET) |-> !nmi && !irq)
		else $error("nmi or irq high during reset");

	// ROM data reaches the CPU only on a memory request unless video claims the read
	romNeedsMreq: assert property (@(posedge MCLK) disable iff (RESET)
		romValid |-> cpuMreq && (vidValid || cpuRdata == romData))
		else $error("romValid without cpuMreq or ROM data missing from cpuRdata");

	// nmi only moves two cycles after a line tick or a clear of channel 0
	nmiStable: assert property (@(posedge MCLK) disable iff (RESET)
		$changed(nmi) |-> $past(tickStep || maskClear[0], 2))
		else $error("nmi changed without a line tick or mask clear");
endmodule

bind mainBoard mainBoardChecks u_checks (
	.MCLK(MCLK), .RESET(RESET), .cpuMreq(cpuMreq), .romValid(romValid),
	.vidValid(vidValid), .cpuRdata(cpuRdata), .romData(romData),
	.nmi(nmi), .irq(irq), .tickStep(tickStep), .maskClear(maskClear)
);

// ==== dv/mainBoardTests.svh ====
// Directed tests for the main board, included into the testbench module.
// Expected values follow the memory map and interrupt rules of the board.

	// ROM address by region: banked window, upper 16 KB, lower 32 KB
	function automatic logic [15:0] mapRom(input logic [15:0] addr, input logic [2:0] bank);
		if (addr >= 16'hF800) begin
			return 16'hC000 | (16'(bank) << 11) | (addr & 16'h07FF);
		end else if (addr >= 16'h8000) begin
			return 16'h8000 | (addr & 16'h3FFF);
		end
		return addr & 16'h7FFF;
	endfunction

	task automatic resetStateTest();
		int          errsBefore;
		logic [15:0] addr;
		logic [7:0]  rdata;
		logic [15:0] rAddr;
		logic        rValid;
		errsBefore = errCount;
		checkLines(3'b000);
		addr = 16'hF800 | 16'($urandom_range(16'h07FF));
		busRead(addr, 1'b1, rdata, rAddr, rValid);
		checkVal("romAddr", rAddr, mapRom(addr, 3'd0));
		checkVal("romValid", rValid, 1'b1);
		reportTest("reset state", errsBefore);
	endtask

	task automatic romMapTest();
		int          errsBefore;
		logic [2:0]  bank;
		logic [15:0] addr;
		logic        expValid;
		logic [7:0]  rdata;
		logic [15:0] rAddr;
		logic        rValid;
		errsBefore = errCount;
		bank = 3'($urandom_range(7));
		busWrite(mainBusPkg::ADDR_BANKCTL, {bank, 5'($urandom)});
		for (int i = 0; i < 12; i++) begin
			case (i % 3)
				0: addr = 16'hF800 | 16'($urandom_range(16'h07FF));
				1: addr = 16'h8000 + 16'($urandom_range(16'h77FF));
				default: addr = 16'($urandom_range(16'h7FFF));
			endcase
			// I/O space C000-F7FF is not ROM
			expValid = (addr >= 16'hF800) || (addr < 16'hC000);
			@(negedge MCLK);
			romData = 8'($urandom);
			busRead(addr, 1'b1, rdata, rAddr, rValid);
			checkVal("romAddr", rAddr, mapRom(addr, bank));
			checkVal("romValid", rValid, expValid);
			if (expValid) begin
				checkVal("cpuRdata", rdata, romData);
			end
		end
		reportTest("rom mapping", errsBefore);
	endtask

	task automatic readExpect(input logic [15:0] addr, input logic mreq, input logic [7:0] exp);
		logic [7:0]  rdata;
		logic [15:0] rAddr;
		logic        rValid;
		busRead(addr, mreq, rdata, rAddr, rValid);
		checkVal("cpuRdata", rdata, exp);
	endtask

	task automatic readSelectTest();
		int         errsBefore;
		logic [7:0] sysByte;
		errsBefore = errCount;
		@(negedge MCLK);
		sysIn = 3'($urandom);
		p1In  = 6'($urandom);
		p2In  = 6'($urandom);
		dsw0  = 8'($urandom);
		dsw1  = 8'($urandom);
		dsw2  = 8'($urandom);
		// Coin at bit 0, starts at bits 3 and 4, all active low
		sysByte = ~{3'b000, sysIn[2], sysIn[1], 2'b00, sysIn[0]};
		readExpect(16'hF603, 1'b1, sysByte);
		readExpect(16'hF602, 1'b1, ~{2'b00, p1In});
		readExpect(16'hF601, 1'b1, ~{2'b00, p2In});
		readExpect(16'hF600, 1'b1, dsw2);
		readExpect({8'hF2, 8'($urandom)}, 1'b1, dsw0);
		readExpect({8'hF4, 8'($urandom)}, 1'b1, dsw1);
		@(negedge MCLK);
		vidValid = 1'b1;
		vidRdata = 8'($urandom);
		readExpect(16'hF603, 1'b1, vidRdata);
		@(negedge MCLK);
		vidValid = 1'b0;
		readExpect(16'hE000 | 16'($urandom_range(16'h0FFF)), 1'b0, 8'h00);
		reportTest("read selection", errsBefore);
	endtask

	task automatic nmiTest();
		int errsBefore;
		errsBefore = errCount;
		writeMask(3'b001);
		for (int i = 0; i < 8; i++) begin
			stepLines();
		end
		reportTest("nmi generation", errsBefore);
	endtask

	task automatic irqMaskTest();
		int errsBefore;
		errsBefore = errCount;
		writeMask(3'b110);
		// Step until tick bit 3 or 4 rises
		for (int i = 0; i < 24 && !(modelChan[1] | modelChan[2]); i++) begin
			stepLines();
		end
		assert (irq === 1'b1) else begin
			$display("irq never rose within 24 line steps");
			errCount++;
		end
		// Frozen board ignores the line counter
		@(negedge MCLK);
		clkEn = 1'b0;
		vPos  = vPos + 9'd16;
		for (int i = 0; i < 6; i++) begin
			@(negedge MCLK);
			checkVal("tickStep", u_dut.tickStep, 1'b0);
			checkLines(modelChan);
		end
		vPos  = vPos - 9'd16;
		clkEn = 1'b1;
		writeMask(3'b000);
		reportTest("irq masking", errsBefore);
	endtask

// ==== dv/mainBoardTb.sv ====
// Testbench for the main board glue, acting as the CPU bus and the line counter.
// Directed tests come from the included test header, results print at the end.
module mainBoardTb;
	logic        MCLK;
	logic        RESET;
	logic        clkEn;
	logic [8:0]  vPos;
	logic [15:0] cpuAddr;
	logic [7:0]  cpuWdata;
	logic        cpuMreq;
	logic        cpuWr;
	logic [7:0]  cpuRdata;
	logic [2:0]  sysIn;
	logic [5:0]  p1In;
	logic [5:0]  p2In;
	logic [7:0]  dsw0;
	logic [7:0]  dsw1;
	logic [7:0]  dsw2;
	logic        vidValid;
	logic [7:0]  vidRdata;
	logic [15:0] romAddr;
	logic        romValid;
	logic [7:0]  romData;
	logic        nmi;
	logic        irq;

	int          errCount;
	int          testsFailed;
	// Reference model of the tick counter, mask and channel levels
	logic [8:0]  modelTick;
	logic [2:0]  modelMask;
	logic [2:0]  modelChan;

	mainBoard u_dut (.*);

	initial begin
		MCLK = 1'b0;
		forever #10 MCLK = ~MCLK;
	end

	task automatic checkVal(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			errCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errsBefore);
		if (errCount == errsBefore) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errCount - errsBefore);
			testsFailed++;
		end
	endtask

	// One write cycle, bus idle again on the next falling edge
	task automatic busWrite(input logic [15:0] addr, input logic [7:0] data);
		@(negedge MCLK);
		cpuAddr  = addr;
		cpuWdata = data;
		cpuMreq  = 1'b1;
		cpuWr    = 1'b1;
		@(negedge MCLK);
		cpuMreq = 1'b0;
		cpuWr   = 1'b0;
	endtask

	// Read outputs are combinational, sampled half a cycle after the drive
	task automatic busRead(input logic [15:0] addr, input logic mreq, output logic [7:0] rdata,
			output logic [15:0] rAddr, output logic rValid);
		@(negedge MCLK);
		cpuAddr = addr;
		cpuMreq = mreq;
		cpuWr   = 1'b0;
		@(posedge MCLK);
		rdata  = cpuRdata;
		rAddr  = romAddr;
		rValid = romValid;
	endtask

	task automatic checkLines(input logic [2:0] chan);
		checkVal("nmi", nmi, chan[0]);
		checkVal("irq", irq, chan[1] | chan[2]);
	endtask

	// Moves vPos to the next 16-line boundary and checks the two-cycle response
	task automatic stepLines();
		logic [8:0] nextTick;
		logic [8:0] fire;
		logic [2:0] prevChan;
		logic       seen;
		nextTick  = modelTick + 9'd1;
		// Bits that go from 0 to 1 on this step
		fire      = (nextTick ^ modelTick) & nextTick;
		modelTick = nextTick;
		prevChan  = modelChan;
		modelChan = {fire[4] & modelMask[2], fire[3] & modelMask[1], fire[0] & modelMask[0]};
		@(negedge MCLK);
		vPos = vPos + 9'd16;
		seen = 1'b0;
		for (int i = 0; i < 4 && !seen; i++) begin
			@(negedge MCLK);
			seen = u_dut.tickStep;
		end
		assert (seen) else begin
			$display("no line tick seen after vPos moved to %0d", vPos);
			errCount++;
		end
		@(negedge MCLK);
		checkLines(prevChan);
		@(negedge MCLK);
		checkLines(modelChan);
	endtask

	// Cleared mask bits drop their channel, lines follow one cycle later
	task automatic writeMask(input logic [2:0] mask);
		logic [2:0] prevChan;
		prevChan  = modelChan;
		modelMask = mask;
		modelChan = modelChan & mask;
		busWrite(mainBusPkg::ADDR_IRQCTL, {5'($urandom), mask});
		checkLines(prevChan);
		@(negedge MCLK);
		checkLines(modelChan);
	endtask

	`include "mainBoardTests.svh"

	initial begin
		void'($urandom(60998));
		errCount    = 0;
		testsFailed = 0;
		modelTick   = '0;
		modelMask   = '0;
		modelChan   = '0;
		RESET    = 1'b1;
		clkEn    = 1'b1;
		vPos     = '0;
		cpuAddr  = '0;
		cpuWdata = '0;
		cpuMreq  = 1'b0;
		cpuWr    = 1'b0;
		sysIn    = '0;
		p1In     = '0;
		p2In     = '0;
		dsw0     = '0;
		dsw1     = '0;
		dsw2     = '0;
		vidValid = 1'b0;
		vidRdata = '0;
		romData  = '0;
		for (int i = 0; i < 16; i++) begin
			@(negedge MCLK);
		end
		RESET = 1'b0;
		resetStateTest();
		romMapTest();
		readSelectTest();
		nmiTest();
		irqMaskTest();
		$display("tests run 5, tests with errors %0d, checks failed %0d", testsFailed, errCount);
		if (errCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end
endmodule

// ==== mainBoard.f ====
+incdir+dv
common/mainBusPkg.sv
common/cpuBusIf.sv
design/busDecoder.sv
design/ctrlRegs.sv
irqGen/vlineTicker.sv
irqGen/irqChannel.sv
irqGen/irqMerge.sv
design/mainBoard.sv
dv/mainBoard_assertions.sv
dv/mainBoardTb.sv

// ==== Bender.yml ====
package:
  name: main_board

sources:
  - common/mainBusPkg.sv
  - common/cpuBusIf.sv
  - design/busDecoder.sv
  - design/ctrlRegs.sv
  - irqGen/vlineTicker.sv
  - irqGen/irqChannel.sv
  - irqGen/irqMerge.sv
  - design/mainBoard.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/mainBoard_assertions.sv
      - dv/mainBoardTb.sv
